// ==== Bender.yml ====
package:
  name: rv_top

sources:
  - files:
      - logic/rv_pkg.sv
      - logic/mem_req_if.sv
      - logic/rv_decoder.sv
      - logic/reg_file.sv
      - logic/apb_requester.sv
      - logic/core_sequencer.sv
      - logic/rv_top.sv
  - target: simulation
    files:
      - sim/apb_mem_model.sv
      - sim/tb_rv_top.sv

// ==== list.f ====
logic/rv_pkg.sv
logic/mem_req_if.sv
logic/rv_decoder.sv
logic/reg_file.sv
logic/apb_requester.sv
logic/core_sequencer.sv
logic/rv_top.sv
sim/apb_mem_model.sv
sim/tb_rv_top.sv

// ==== logic/apb_requester.sv ====
`timescale 1ns/100ps

module apb_requester (
    input  logic         clk,
    input  logic         reset,
    mem_req_if.completer req,
    output logic [31:0]  paddr,
    output logic         psel,
    output logic         penable,
    output logic         pwrite,
    output logic [31:0]  pwdata,
    output logic [3:0]   pstrb,
    input  logic [31:0]  prdata,
    input  logic         pready
);

    // state lives in {psel, penable}
    // 00 idle, 10 setup, 11 access
    always_ff @(posedge clk) begin
        if (reset) begin
            psel    <= 1'b0;
            penable <= 1'b0;
            pwrite  <= 1'b0;
        end else if (!psel) begin
            if (req.valid) begin
                psel   <= 1'b1;
                pwrite <= req.write;
            end
        end else if (!penable) begin
            penable <= 1'b1;
        end else if (pready) begin
            // transfer finished, back to idle
            psel    <= 1'b0;
            penable <= 1'b0;
        end
    end

    // payload captured at the start of a transfer
    always_ff @(posedge clk) begin
        if (!psel && req.valid) begin
            paddr  <= req.addr;
            pwdata <= req.wdata;
            pstrb  <= req.strb;
        end
    end

    assign req.done  = psel && penable && pready;
    assign req.rdata = prdata;

endmodule

// ==== logic/core_sequencer.sv ====
`timescale 1ns/100ps

module core_sequencer import rv_pkg::*; (
    input  logic         clk,
    input  logic         reset,
    mem_req_if.requester req,
    output logic [31:0]  inst,
    input  dec_t         dec,
    input  logic [31:0]  rs1_data,
    input  logic [31:0]  rs2_data,
    output logic         reg_wen,
    output logic [4:0]   reg_waddr,
    output logic [31:0]  reg_wdata,
    output logic         halted,
    output logic [31:0]  halt_pc
);

    seq_state_e  state;
    logic [31:0] pc;
    logic [31:0] ir;
    logic [31:0] src1;
    logic [31:0] src2;
    logic [31:0] sum;
    logic [31:0] pc_plus4;
    logic [31:0] next_pc;
    logic [1:0]  lane;
    logic [7:0]  load_byte;
    logic [31:0] load_data;
    logic        mem_write;

    assign inst = ir;

    // the one adder
    assign src1 = dec.src1_is_pc ? pc : rs1_data;
    assign src2 = dec.src2_is_imm ? dec.imm : rs2_data;
    assign sum  = src1 + src2;

    assign pc_plus4 = pc + 32'd4;

    always_comb begin
        if (dec.is_jalr) begin
            next_pc = {sum[31:1], 1'b0};
        end else if (dec.is_jal) begin
            next_pc = sum;
        end else begin
            next_pc = pc_plus4;
        end
    end

    // byte lane from the low address bits
    assign lane      = sum[1:0];
    assign load_byte = req.rdata[{lane, 3'b000} +: 8];
    assign load_data = dec.is_byte ? {24'd0, load_byte} : req.rdata;

    // request stays up for the whole fetch or mem state
    assign mem_write = (state == st_mem) && dec.is_store;
    assign req.valid = (state == st_fetch) || (state == st_mem);
    assign req.write = mem_write;
    assign req.addr  = (state == st_mem) ? {sum[31:2], 2'b00} : pc;
    assign req.wdata = dec.is_byte ? (rs2_data << {lane, 3'b000}) : rs2_data;

    always_comb begin
        if (!mem_write) begin
            req.strb = 4'b0000;
        end else if (dec.is_byte) begin
            req.strb = 4'b0001 << lane;
        end else begin
            req.strb = 4'b1111;
        end
    end

    // writeback source
    always_comb begin
        case (dec.wb_sel)
            wb_alu:  reg_wdata = sum;
            wb_mem:  reg_wdata = load_data;
            wb_pc4:  reg_wdata = pc_plus4;
            default: reg_wdata = dec.imm;
        endcase
    end

    // loads write in mem when done arrives, all others in execute
    assign reg_wen = dec.reg_wen &&
                     (((state == st_execute) && !dec.is_load) ||
                      ((state == st_mem) && req.done));
    assign reg_waddr = dec.rd;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= st_fetch;
            pc    <= reset_pc;
        end else begin
            case (state)
                st_fetch: begin
                    if (req.done) begin
                        state <= st_execute;
                    end
                end
                st_execute: begin
                    if (dec.is_ebreak) begin
                        // pc stays on the ebreak
                        state <= st_halt;
                    end else if (dec.is_load || dec.is_store) begin
                        state <= st_mem;
                    end else begin
                        pc    <= next_pc;
                        state <= st_fetch;
                    end
                end
                st_mem: begin
                    if (req.done) begin
                        pc    <= next_pc;
                        state <= st_fetch;
                    end
                end
                default: begin
                    state <= st_halt;
                end
            endcase
        end
    end

    // instruction register
    always_ff @(posedge clk) begin
        if (state == st_fetch && req.done) begin
            ir <= req.rdata;
        end
    end

    assign halted  = (state == st_halt);
    assign halt_pc = pc;

endmodule

// ==== logic/mem_req_if.sv ====
`timescale 1ns/100ps

interface mem_req_if;

    logic        valid;
    logic        write;
    logic [31:0] addr;
    logic [31:0] wdata;
    logic [3:0]  strb;
    // one-cycle pulse, rdata valid alongside
    logic        done;
    logic [31:0] rdata;

    modport requester (
        output valid,
        output write,
        output addr,
        output wdata,
        output strb,
        input  done,
        input  rdata
    );

    modport completer (
        input  valid,
        input  write,
        input  addr,
        input  wdata,
        input  strb,
        output done,
        output rdata
    );

endinterface

// ==== logic/reg_file.sv ====
`timescale 1ns/100ps

module reg_file (
    input  logic        clk,
    input  logic [4:0]  raddr1,
    input  logic [4:0]  raddr2,
    input  logic [4:0]  waddr,
    input  logic        wen,
    input  logic [31:0] wdata,
    output logic [31:0] rdata1,
    output logic [31:0] rdata2
);

    // x1..x31, x0 is hardwired
    logic [31:0] regs [1:31];

    always_ff @(posedge clk) begin
        if (wen && waddr != 5'd0) begin
            regs[waddr] <= wdata;
        end
    end

    // asynchronous reads
    assign rdata1 = (raddr1 == 5'd0) ? 32'd0 : regs[raddr1];
    assign rdata2 = (raddr2 == 5'd0) ? 32'd0 : regs[raddr2];

endmodule

// ==== logic/rv_decoder.sv ====
`timescale 1ns/100ps

module rv_decoder import rv_pkg::*; (
    input  logic [31:0] inst,
    output dec_t        dec
);

    inst_u       word;
    logic [31:0] imm_i;
    logic [31:0] imm_s;
    logic [31:0] imm_u;
    logic [31:0] imm_j;

    assign word = inst;

    // sign-extended immediates per format
    assign imm_i = {{20{word.i.imm[11]}}, word.i.imm};
    assign imm_s = {{20{word.s.imm_hi[6]}}, word.s.imm_hi, word.s.imm_lo};
    assign imm_u = {word.u.imm, 12'b0};
    assign imm_j = {{11{word.j.imm_20}}, word.j.imm_20, word.j.imm_19_12,
                    word.j.imm_11, word.j.imm_10_1, 1'b0};

    always_comb begin
        dec        = '0;
        dec.rs1    = word.r.rs1;
        dec.rs2    = word.r.rs2;
        dec.rd     = word.r.rd;
        dec.wb_sel = wb_alu;
        case (word.r.opcode)
            op_lui: begin
                dec.imm     = imm_u;
                dec.reg_wen = 1'b1;
                dec.wb_sel  = wb_imm;
            end
            op_auipc: begin
                dec.imm         = imm_u;
                dec.reg_wen     = 1'b1;
                dec.src1_is_pc  = 1'b1;
                dec.src2_is_imm = 1'b1;
            end
            op_jal: begin
                // adder forms pc + imm as the target
                dec.imm         = imm_j;
                dec.reg_wen     = 1'b1;
                dec.is_jal      = 1'b1;
                dec.src1_is_pc  = 1'b1;
                dec.src2_is_imm = 1'b1;
                dec.wb_sel      = wb_pc4;
            end
            op_jalr: begin
                dec.imm = imm_i;
                if (word.i.funct3 == f3_add) begin
                    dec.reg_wen     = 1'b1;
                    dec.is_jalr     = 1'b1;
                    dec.src2_is_imm = 1'b1;
                    dec.wb_sel      = wb_pc4;
                end
            end
            op_op: begin
                if (word.r.funct3 == f3_add && word.r.funct7 == 7'b0) begin
                    dec.reg_wen = 1'b1;
                end
            end
            op_op_imm: begin
                dec.imm = imm_i;
                if (word.i.funct3 == f3_add) begin
                    dec.reg_wen     = 1'b1;
                    dec.src2_is_imm = 1'b1;
                end
            end
            op_load: begin
                dec.imm = imm_i;
                if (word.i.funct3 == f3_word || word.i.funct3 == f3_byte_u) begin
                    dec.reg_wen     = 1'b1;
                    dec.is_load     = 1'b1;
                    dec.is_byte     = (word.i.funct3 == f3_byte_u);
                    dec.src2_is_imm = 1'b1;
                    dec.wb_sel      = wb_mem;
                end
            end
            op_store: begin
                dec.imm = imm_s;
                // sb is funct3 000
                if (word.s.funct3 == f3_word || word.s.funct3 == f3_add) begin
                    dec.is_store    = 1'b1;
                    dec.is_byte     = (word.s.funct3 == f3_add);
                    dec.src2_is_imm = 1'b1;
                end
            end
            op_system: begin
                dec.is_ebreak = (inst == ebreak_word);
            end
            default: begin
                // unknown, leave everything off
                dec.imm = imm_i;
            end
        endcase
    end

endmodule

// ==== logic/rv_pkg.sv ====
package rv_pkg;

    // program counter after reset
    localparam logic [31:0] reset_pc = 32'h8000_0000;

    // full ebreak encoding
    localparam logic [31:0] ebreak_word = 32'h0010_0073;

    // major opcodes
    localparam logic [6:0] op_lui    = 7'b0110111;
    localparam logic [6:0] op_auipc  = 7'b0010111;
    localparam logic [6:0] op_jal    = 7'b1101111;
    localparam logic [6:0] op_jalr   = 7'b1100111;
    localparam logic [6:0] op_op     = 7'b0110011;
    localparam logic [6:0] op_op_imm = 7'b0010011;
    localparam logic [6:0] op_load   = 7'b0000011;
    localparam logic [6:0] op_store  = 7'b0100011;
    localparam logic [6:0] op_system = 7'b1110011;

    // funct3 codes, sb and jalr share 000 with add
    localparam logic [2:0] f3_add    = 3'b000;
    localparam logic [2:0] f3_word   = 3'b010;
    localparam logic [2:0] f3_byte_u = 3'b100;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0] imm_hi;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;
        logic [6:0] opcode;
    } s_fmt_t;

    typedef struct packed {
        logic [19:0] imm;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } u_fmt_t;

    typedef struct packed {
        logic       imm_20;
        logic [9:0] imm_10_1;
        logic       imm_11;
        logic [7:0] imm_19_12;
        logic [4:0] rd;
        logic [6:0] opcode;
    } j_fmt_t;

    // one instruction word, five views
    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
        s_fmt_t s;
        u_fmt_t u;
        j_fmt_t j;
    } inst_u;

    typedef enum logic [1:0] {
        wb_alu,
        wb_mem,
        wb_pc4,
        wb_imm
    } wb_sel_e;

    typedef struct packed {
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [4:0]  rd;
        logic [31:0] imm;
        logic        reg_wen;
        logic        is_load;
        logic        is_store;
        logic        is_byte;
        logic        is_jal;
        logic        is_jalr;
        logic        src1_is_pc;
        logic        src2_is_imm;
        logic        is_ebreak;
        wb_sel_e     wb_sel;
    } dec_t;

    typedef enum logic [1:0] {
        st_fetch,
        st_execute,
        st_mem,
        st_halt
    } seq_state_e;

endpackage

// ==== logic/rv_top.sv ====
`timescale 1ns/100ps

module rv_top import rv_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    output logic [31:0] paddr,
    output logic        psel,
    output logic        penable,
    output logic        pwrite,
    output logic [31:0] pwdata,
    output logic [3:0]  pstrb,
    input  logic [31:0] prdata,
    input  logic        pready,
    output logic        halted,
    output logic [31:0] halt_pc
);

    logic [31:0] inst;
    dec_t        dec;
    logic [31:0] rs1_data;
    logic [31:0] rs2_data;
    logic        reg_wen;
    logic [4:0]  reg_waddr;
    logic [31:0] reg_wdata;

    mem_req_if mem_req ();

    core_sequencer seq0 (
        .clk       (clk),
        .reset     (reset),
        .req       (mem_req.requester),
        .inst      (inst),
        .dec       (dec),
        .rs1_data  (rs1_data),
        .rs2_data  (rs2_data),
        .reg_wen   (reg_wen),
        .reg_waddr (reg_waddr),
        .reg_wdata (reg_wdata),
        .halted    (halted),
        .halt_pc   (halt_pc)
    );

    rv_decoder dec0 (
        .inst (inst),
        .dec  (dec)
    );

    reg_file rf0 (
        .clk    (clk),
        .raddr1 (dec.rs1),
        .raddr2 (dec.rs2),
        .waddr  (reg_waddr),
        .wen    (reg_wen),
        .wdata  (reg_wdata),
        .rdata1 (rs1_data),
        .rdata2 (rs2_data)
    );

    apb_requester apb0 (
        .clk     (clk),
        .reset   (reset),
        .req     (mem_req.completer),
        .paddr   (paddr),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .pwdata  (pwdata),
        .pstrb   (pstrb),
        .prdata  (prdata),
        .pready  (pready)
    );

endmodule

// ==== sim/apb_mem_model.sv ====
`timescale 1ns/100ps

module apb_mem_model import rv_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  logic [31:0] paddr,
    input  logic        psel,
    input  logic        penable,
    input  logic        pwrite,
    input  logic [31:0] pwdata,
    input  logic [3:0]  pstrb,
    output logic [31:0] prdata,
    output logic        pready
);

    integer     seed;
    int         protocol_errors;
    // 8 KiB starting at reset_pc
    logic [7:0] mem [0:8191];

    initial begin
        seed            = 32'hbdba;
        protocol_errors = 0;
        pready          = 1'b0;
        prdata          = 32'd0;
    end

    function automatic logic mapped(input logic [31:0] addr);
        return (addr - reset_pc) < 32'd8192;
    endfunction

    function automatic logic [31:0] read_word(input logic [31:0] addr);
        logic [31:0] offset;
        offset = (addr - reset_pc) & 32'h0000_1ffc;
        return {mem[offset + 3], mem[offset + 2], mem[offset + 1], mem[offset]};
    endfunction

    task automatic write_word(input logic [31:0] addr, input logic [31:0] data);
        logic [31:0] offset;
        offset = (addr - reset_pc) & 32'h0000_1ffc;
        for (int k = 0; k < 4; k++) begin
            mem[offset + k] = data[8 * k +: 8];
        end
    endtask

    // background pattern, differs for every word address
    task automatic fill_memory();
        logic [31:0] addr;
        for (int i = 0; i < 2048; i++) begin
            addr = reset_pc + 32'(i) * 4;
            write_word(addr, {addr[15:0], addr[31:16]} ^ 32'h5a3c_c3a5);
        end
    endtask

    task automatic report_protocol(input string what);
        protocol_errors++;
        $display("APB protocol error at %0t: %s", $time, what);
    endtask

    // random wait states, roughly one access in four stalls
    always @(negedge clk) begin
        if (reset || !psel) begin
            pready <= 1'b0;
        end else begin
            pready <= ($random(seed) & 3) != 0;
            prdata <= mapped(paddr) ? read_word(paddr) : 32'd0;
        end
    end

    always @(posedge clk) begin : write_port
        logic [31:0] offset;
        if (!reset && psel && penable && pready) begin
            offset = (paddr - reset_pc) & 32'h0000_1ffc;
            if (!mapped(paddr)) begin
                report_protocol($sformatf("access outside the memory at %h", paddr));
            end else if (pwrite) begin
                for (int k = 0; k < 4; k++) begin
                    if (pstrb[k]) begin
                        mem[offset + k] <= pwdata[8 * k +: 8];
                    end
                end
            end
        end
    end

    assert property (@(negedge clk) reset |-> !psel && !penable && !pwrite)
        else report_protocol("psel, penable or pwrite high during reset");

    assert property (@(posedge clk) disable iff (reset) $rose(psel) |-> !penable)
        else report_protocol("psel rose together with penable");

    assert property (@(posedge clk) disable iff (reset) penable |-> psel)
        else report_protocol("penable high without psel");

    assert property (@(posedge clk) disable iff (reset)
        psel && !penable |=> psel && penable && $stable(paddr) && $stable(pwrite)
                             && $stable(pwdata) && $stable(pstrb))
        else report_protocol("setup phase not followed by a matching access phase");

    // back-pressure holds the access phase
    assert property (@(posedge clk) disable iff (reset)
        psel && penable && !pready |=> psel && penable && $stable(paddr)
                                       && $stable(pwrite) && $stable(pwdata) && $stable(pstrb))
        else report_protocol("fields changed while pready was low");

    assert property (@(posedge clk) disable iff (reset)
        psel && penable && pready |=> !psel && !penable)
        else report_protocol("psel or penable stayed high after the transfer");

endmodule

// ==== sim/tb_rv_top.sv ====
`timescale 1ns/100ps

module tb_rv_top import rv_pkg::*; ();

    logic        clk;
    logic        reset;
    logic [31:0] paddr;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [31:0] pwdata;
    logic [3:0]  pstrb;
    logic [31:0] prdata;
    logic        pready;
    logic        halted;
    logic [31:0] halt_pc;

    int          result_errors = 0;
    int unsigned cycles = 0;
    int unsigned cycle_limit;
    logic [31:0] prog [$];

    // constants shared by the program and the checks
    logic [31:0] data_base = 32'h8000_1000;
    logic [19:0] lui_imm   = 20'h12345;
    logic [19:0] auipc_imm = 20'h00001;
    logic [11:0] addi_imm  = 12'h678;
    logic [11:0] neg_imm   = 12'hffb;
    logic [31:0] lbu_word  = 32'h11f0_2233;
    logic [31:0] auipc_addr;
    logic [31:0] jal_addr;
    logic [31:0] jalr_addr;
    logic [31:0] ebreak_addr;
    logic [31:0] lane_before [0:3];
    logic [31:0] jal_skip_before;
    logic [31:0] jalr_skip_before;

    rv_top dut0 (
        .clk     (clk),
        .reset   (reset),
        .paddr   (paddr),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .pwdata  (pwdata),
        .pstrb   (pstrb),
        .prdata  (prdata),
        .pready  (pready),
        .halted  (halted),
        .halt_pc (halt_pc)
    );

    apb_mem_model mem0 (
        .clk     (clk),
        .reset   (reset),
        .paddr   (paddr),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .pwdata  (pwdata),
        .pstrb   (pstrb),
        .prdata  (prdata),
        .pready  (pready)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) begin
        if (reset) begin
            cycles <= 0;
        end else begin
            cycles <= cycles + 1;
        end
    end

    // once halted the bus must stay quiet
    always @(posedge clk) begin
        if (!reset && halted) begin
            assert (!psel) else begin
                result_errors++;
                $display("APB transfer to %h started after halt", paddr);
            end
        end
    end

    // RV32I encodings
    function automatic logic [31:0] utype(input logic [6:0] op, input logic [4:0] rd,
                                          input logic [19:0] imm);
        return {imm, rd, op};
    endfunction

    function automatic logic [31:0] itype(input logic [6:0] op, input logic [4:0] rd,
                                          input logic [2:0] f3, input logic [4:0] rs1,
                                          input logic [11:0] imm);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] stype(input logic [2:0] f3, input logic [4:0] rs1,
                                          input logic [4:0] rs2, input logic [11:0] imm);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'b0100011};
    endfunction

    function automatic logic [31:0] add_word(input logic [4:0] rd, input logic [4:0] rs1,
                                             input logic [4:0] rs2);
        return {7'd0, rs2, rs1, 3'b000, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] jal_word(input logic [4:0] rd, input logic [20:0] off);
        return {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
    endfunction

    function automatic logic [31:0] next_addr();
        return reset_pc + 32'(prog.size()) * 4;
    endfunction

    task automatic emit(input logic [31:0] word);
        prog.push_back(word);
    endtask

    task automatic build_program();
        // x10 points at the data area
        emit(utype(7'b0110111, 5'd10, data_base[31:12]));
        emit(utype(7'b0110111, 5'd1, lui_imm));
        auipc_addr = next_addr();
        emit(utype(7'b0010111, 5'd2, auipc_imm));
        emit(itype(7'b0010011, 5'd3, 3'b000, 5'd1, addi_imm));
        emit(itype(7'b0010011, 5'd4, 3'b000, 5'd0, neg_imm));
        emit(add_word(5'd5, 5'd3, 5'd4));
        for (int r = 1; r <= 5; r++) begin
            emit(stype(3'b010, 5'd10, 5'(r), 12'(4 * (r - 1))));
        end
        // lw back, then sb of x3 low byte into four lanes
        emit(itype(7'b0000011, 5'd6, 3'b010, 5'd10, 12'h008));
        emit(stype(3'b010, 5'd10, 5'd6, 12'h014));
        for (int k = 0; k < 4; k++) begin
            emit(stype(3'b000, 5'd10, 5'd3, 12'(32 + 5 * k)));
        end
        emit(itype(7'b0000011, 5'd9, 3'b100, 5'd10, 12'h032));
        emit(stype(3'b010, 5'd10, 5'd9, 12'h034));
        // marker value in x12
        emit(itype(7'b0010011, 5'd12, 3'b000, 5'd0, 12'h55a));
        jal_addr = next_addr();
        emit(jal_word(5'd13, 21'd8));
        emit(stype(3'b010, 5'd10, 5'd12, 12'h040));
        emit(stype(3'b010, 5'd10, 5'd13, 12'h044));
        // target gets bit 0 set, skips one store
        emit(utype(7'b0010111, 5'd14, 20'd0));
        jalr_addr = next_addr();
        emit(itype(7'b1100111, 5'd15, 3'b000, 5'd14, 12'd13));
        emit(stype(3'b010, 5'd10, 5'd12, 12'h048));
        emit(stype(3'b010, 5'd10, 5'd15, 12'h04c));
        emit(itype(7'b0010011, 5'd0, 3'b000, 5'd0, 12'h123));
        emit(stype(3'b010, 5'd10, 5'd0, 12'h050));
        ebreak_addr = next_addr();
        emit(ebreak_word);
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (actual === expected) else begin
            result_errors++;
            $display("FAILED %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    task automatic check_word(input string name, input logic [31:0] offset,
                              input logic [31:0] expected);
        check_value(name, expected, mem0.read_word(data_base + offset));
    endtask

    task automatic run_checks();
        logic [31:0] x1_exp;
        logic [31:0] x3_exp;
        logic [31:0] x4_exp;
        logic [31:0] lane_exp;
        x1_exp = {lui_imm, 12'd0};
        x3_exp = x1_exp + {{20{addi_imm[11]}}, addi_imm};
        x4_exp = {{20{neg_imm[11]}}, neg_imm};
        check_word("lui", 32'h00, x1_exp);
        check_word("auipc", 32'h04, auipc_addr + {auipc_imm, 12'd0});
        check_word("addi", 32'h08, x3_exp);
        check_word("addi negative", 32'h0c, x4_exp);
        check_word("add", 32'h10, x3_exp + x4_exp);
        check_word("lw", 32'h14, x3_exp);
        for (int k = 0; k < 4; k++) begin
            lane_exp = lane_before[k];
            lane_exp[8 * k +: 8] = x3_exp[7:0];
            check_word($sformatf("sb lane %0d", k), 32'h20 + 4 * k, lane_exp);
        end
        check_word("lbu", 32'h34, {24'd0, lbu_word[23:16]});
        check_word("jal skip", 32'h40, jal_skip_before);
        check_word("jal link", 32'h44, jal_addr + 4);
        check_word("jalr skip", 32'h48, jalr_skip_before);
        check_word("jalr link", 32'h4c, jalr_addr + 4);
        check_word("x0 store", 32'h50, 32'd0);
        check_value("halted", 32'd1, {31'd0, halted});
        check_value("halt_pc", ebreak_addr, halt_pc);
    endtask

    initial begin : main
        reset = 1'b1;
        // 40 instructions at up to 12 cycles, plus margin
        cycle_limit = 40 * 12 + 200;
        build_program();
        mem0.fill_memory();
        for (int i = 0; i < prog.size(); i++) begin
            mem0.write_word(reset_pc + 32'(i) * 4, prog[i]);
        end
        mem0.write_word(data_base + 32'h30, lbu_word);
        for (int k = 0; k < 4; k++) begin
            lane_before[k] = mem0.read_word(data_base + 32'h20 + 4 * k);
        end
        jal_skip_before  = mem0.read_word(data_base + 32'h40);
        jalr_skip_before = mem0.read_word(data_base + 32'h48);

        repeat (10) @(negedge clk);
        reset = 1'b0;

        while (!halted && cycles < cycle_limit) begin
            @(negedge clk);
        end
        if (!halted) begin
            result_errors++;
            $display("timeout: core never halted within %0d cycles", cycle_limit);
        end else begin
            // watch the bus a while after halt
            repeat (20) @(negedge clk);
            run_checks();
        end

        $display("errors: results %0d, apb protocol %0d", result_errors, mem0.protocol_errors);
        if (result_errors == 0 && mem0.protocol_errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule
